// File: design/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] inst_t;    // Raw instruction word
    typedef logic [31:0] addr_t;    // Program counter
    typedef logic [31:0] word_t;    // Register value
    typedef logic [4:0]  reg_idx_t; // Register file index

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_R     = 7'b0110011, // ADD, SUB, shifts, compares, logic
        OPC_I     = 7'b0010011, // Immediate ALU ops
        OPC_IL    = 7'b0000011, // Loads
        OPC_JALR  = 7'b1100111,
        OPC_S     = 7'b0100011, // Stores
        OPC_B     = 7'b1100011, // Branches
        OPC_JAL   = 7'b1101111,
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111,
        OPC_FENCE = 7'b0001111, // FENCE, FENCE.TSO, PAUSE
        OPC_E     = 7'b1110011  // ECALL, EBREAK
    } opcode_t;

    // Depth of the stage buffer between decode and write-back
    localparam int PIPE_STAGES = 4;

    localparam inst_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0
    localparam addr_t PC_INIT  = 32'h0000_0200;

    // funct7 for SUB, SRA and SRAI
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // funct3 codes the decoder and golden model look at
    localparam logic [2:0] F3_ADD  = 3'b000; // Also ADDI, JALR, FENCE
    localparam logic [2:0] F3_SLL  = 3'b001; // SLL and SLLI
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100; // XORI shares it
    localparam logic [2:0] F3_SR   = 3'b101; // SRL, SRA and immediate forms

    // Branch funct3
    localparam logic [2:0] F3_BLT  = 3'b100;

    // Load and store widths
    localparam logic [2:0] F3_B    = 3'b000;
    localparam logic [2:0] F3_H    = 3'b001;
    localparam logic [2:0] F3_W    = 3'b010;
    localparam logic [2:0] F3_BU   = 3'b100;
    localparam logic [2:0] F3_HU   = 3'b101;

    // SYSTEM imm12 values
    localparam logic [11:0] IMM_ECALL  = 12'h000;
    localparam logic [11:0] IMM_EBREAK = 12'h001;

endpackage

// File: design/stage_if.sv
interface stage_if;
    import rv_pkg::*;

    logic  bubble;  // High when the entry is empty
    logic  illegal; // Entry failed the RV32I legality check
    inst_t inst;
    addr_t pc;

    modport source (
        output bubble,
        output illegal,
        output inst,
        output pc
    );

    modport sink (
        input bubble,
        input illegal,
        input inst,
        input pc
    );
endinterface

// File: design/rv_fetch_decode.sv
module rv_fetch_decode (
    input  logic          clk,
    input  logic          rst,
    input  logic          fetch_valid_i,
    input  rv_pkg::inst_t fetch_inst_i,
    input  rv_pkg::addr_t fetch_pc_i,
    input  logic          stall_i,
    input  logic          flush_i,
    stage_if.source       dec_o
);
    import rv_pkg::*;

    logic  bubble_q;
    logic  illegal_q;
    inst_t inst_q;
    addr_t pc_q;
    logic  fetch_legal;

    // RV32I legality table
    function automatic logic is_legal(input inst_t inst);
        opcode_t    opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        opc = opcode_t'(inst[6:0]);
        f3  = inst[14:12];
        f7  = inst[31:25];
        ok  = 1'b0;
        case (opc)
            OPC_LUI, OPC_AUIPC: ok = 1'b1;
            OPC_JAL:   ok = !inst[21];                               // Offset bit 1
            OPC_JALR:  ok = (f3 == F3_ADD) && (inst[21:20] == 2'b00);
            OPC_B:     ok = !(f3 inside {F3_SLT, F3_SLTU}) && !inst[8];
            OPC_IL:    ok = f3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU};
            OPC_S:     ok = f3 inside {F3_B, F3_H, F3_W};
            OPC_I: begin
                if (f3 == F3_SLL) begin
                    ok = (f7 == 7'b0);
                end else if (f3 == F3_SR) begin
                    ok = (f7 == 7'b0) || (f7 == FUNCT7_ALT); // SRLI or SRAI
                end else begin
                    ok = 1'b1;
                end
            end
            OPC_R: begin
                // Only ADD/SUB and SRL/SRA have an alternate form
                ok = (f7 == 7'b0) ||
                     ((f7 == FUNCT7_ALT) && (f3 inside {F3_ADD, F3_SR}));
            end
            OPC_FENCE: ok = (f3 == F3_ADD);
            OPC_E: begin
                ok = (inst[19:7] == 13'b0) &&
                     (inst[31:20] inside {IMM_ECALL, IMM_EBREAK});
            end
            default:   ok = 1'b0;
        endcase
        return ok;
    endfunction

    assign fetch_legal = is_legal(fetch_inst_i);

    // Entry register, flush wins over stall
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            bubble_q  <= 1'b1;
            illegal_q <= 1'b0;
            inst_q    <= NOP_INST;
            pc_q      <= PC_INIT;
        end else if (!stall_i) begin
            bubble_q  <= !fetch_valid_i;
            illegal_q <= fetch_valid_i && !fetch_legal;
            inst_q    <= fetch_valid_i ? fetch_inst_i : NOP_INST; // Bubbles carry a NOP
            pc_q      <= fetch_valid_i ? fetch_pc_i : PC_INIT;
        end
    end

    assign dec_o.bubble  = bubble_q;
    assign dec_o.illegal = illegal_q;
    assign dec_o.inst    = inst_q;
    assign dec_o.pc      = pc_q;

    // An empty entry is never flagged illegal
    a_bubble_not_illegal: assert property (
        @(posedge clk) disable iff (rst) !(dec_o.bubble && dec_o.illegal)
    );

endmodule

// File: design/rv_pipe_follower.sv
module rv_pipe_follower (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall_i,
    input  logic    flush_i,
    stage_if.sink   in_i,
    stage_if.source out_o
);
    import rv_pkg::*;

    logic [PIPE_STAGES-1:0] bubble_q;
    logic [PIPE_STAGES-1:0] illegal_q;
    inst_t                  inst_q [PIPE_STAGES];
    addr_t                  pc_q   [PIPE_STAGES];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            // Every stage turns into an empty NOP slot
            for (int i = 0; i < PIPE_STAGES; i++) begin
                bubble_q[i]  <= 1'b1;
                illegal_q[i] <= 1'b0;
                inst_q[i]    <= NOP_INST;
                pc_q[i]      <= PC_INIT;
            end
        end else if (!stall_i) begin
            bubble_q[0]  <= in_i.bubble;
            illegal_q[0] <= in_i.illegal;
            inst_q[0]    <= in_i.inst;
            pc_q[0]      <= in_i.pc;
            for (int i = 1; i < PIPE_STAGES; i++) begin
                bubble_q[i]  <= bubble_q[i-1];
                illegal_q[i] <= illegal_q[i-1];
                inst_q[i]    <= inst_q[i-1];
                pc_q[i]      <= pc_q[i-1];
            end
        end
    end

    // Last stage feeds write-back
    assign out_o.bubble  = bubble_q[PIPE_STAGES-1];
    assign out_o.illegal = illegal_q[PIPE_STAGES-1];
    assign out_o.inst    = inst_q[PIPE_STAGES-1];
    assign out_o.pc      = pc_q[PIPE_STAGES-1];

    // Nothing from before a flush reaches write-back on the next cycle
    a_flush_empties: assert property (
        @(posedge clk) disable iff (rst) flush_i |=> out_o.bubble
    );

endmodule

// File: design/rv_wb_golden.sv
module rv_wb_golden (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall_i,
    stage_if.sink            in_i,
    output rv_pkg::reg_idx_t rf_raddr1_o,
    output rv_pkg::reg_idx_t rf_raddr2_o,
    input  rv_pkg::word_t    rf_rdata1_i,
    input  rv_pkg::word_t    rf_rdata2_i,
    output logic             wb_valid_o,
    output logic             illegal_o,
    output logic             gold_we_o,
    output rv_pkg::addr_t    wb_pc_o,
    output rv_pkg::addr_t    gold_next_pc_o,
    output rv_pkg::inst_t    wb_inst_o,
    output rv_pkg::reg_idx_t gold_rd_o,
    output rv_pkg::word_t    gold_data_o
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm_u;
    word_t      imm_i;
    word_t      imm_b;
    logic       legal;
    logic       is_lui;
    logic       is_auipc;
    logic       is_xori;
    logic       is_blt;
    word_t      wb_data;
    logic       wb_we;
    addr_t      next_pc;

    assign opcode = opcode_t'(in_i.inst[6:0]);
    assign funct3 = in_i.inst[14:12];
    assign rd     = in_i.inst[11:7];

    // Register file answers in the same cycle
    assign rf_raddr1_o = in_i.inst[19:15];
    assign rf_raddr2_o = in_i.inst[24:20];
    assign rs1_val = (rf_raddr1_o == '0) ? '0 : rf_rdata1_i; // x0 reads zero
    assign rs2_val = (rf_raddr2_o == '0) ? '0 : rf_rdata2_i;

    assign imm_u = {in_i.inst[31:12], 12'b0};
    assign imm_i = {{20{in_i.inst[31]}}, in_i.inst[31:20]};
    assign imm_b = {{19{in_i.inst[31]}}, in_i.inst[31], in_i.inst[7],
                    in_i.inst[30:25], in_i.inst[11:8], 1'b0};

    assign legal    = !in_i.bubble && !in_i.illegal;
    assign is_lui   = legal && (opcode == OPC_LUI);
    assign is_auipc = legal && (opcode == OPC_AUIPC);
    assign is_xori  = legal && (opcode == OPC_I) && (funct3 == F3_XOR);
    assign is_blt   = legal && (opcode == OPC_B) && (funct3 == F3_BLT);

    always_comb begin
        wb_data = '0;
        if (is_lui) begin
            wb_data = imm_u;
        end else if (is_auipc) begin
            wb_data = in_i.pc + imm_u;
        end else if (is_xori) begin
            wb_data = rs1_val ^ imm_i;
        end
    end

    assign wb_we = (is_lui || is_auipc || is_xori) && (rd != '0);

    // Taken BLT jumps, everything else falls through
    assign next_pc = (is_blt && ($signed(rs1_val) < $signed(rs2_val))) ?
                     in_i.pc + imm_b : in_i.pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            illegal_o  <= 1'b0;
            gold_we_o  <= 1'b0;
        end else if (!stall_i) begin
            wb_valid_o <= !in_i.bubble;
            illegal_o  <= !in_i.bubble && in_i.illegal;
            gold_we_o  <= wb_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_pc_o        <= in_i.pc;
            wb_inst_o      <= in_i.inst;
            gold_next_pc_o <= next_pc;
            gold_rd_o      <= rd;
            gold_data_o    <= wb_data;
        end
    end

    // Illegal entries from decode must never produce a register write
    a_we_only_legal: assert property (
        @(posedge clk) disable iff (rst) gold_we_o |-> !illegal_o
    );

endmodule

// File: design/rv_retire_model.sv
module rv_retire_model (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_valid_i,
    input  rv_pkg::inst_t    fetch_inst_i,
    input  rv_pkg::addr_t    fetch_pc_i,
    input  logic             stall_i,
    input  logic             flush_i,
    input  rv_pkg::word_t    rf_rdata1_i,
    input  rv_pkg::word_t    rf_rdata2_i,
    output rv_pkg::reg_idx_t rf_raddr1_o,
    output rv_pkg::reg_idx_t rf_raddr2_o,
    output logic             wb_valid_o,
    output rv_pkg::addr_t    wb_pc_o,
    output rv_pkg::inst_t    wb_inst_o,
    output logic             illegal_o,
    output logic             gold_we_o,
    output rv_pkg::reg_idx_t gold_rd_o,
    output rv_pkg::word_t    gold_data_o,
    output rv_pkg::addr_t    gold_next_pc_o
);

    stage_if dec_if ();  // Decode to buffer
    stage_if wb_if ();   // Buffer to write-back

    rv_fetch_decode u_fetch_decode (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid_i (fetch_valid_i),
        .fetch_inst_i  (fetch_inst_i),
        .fetch_pc_i    (fetch_pc_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .dec_o         (dec_if.source)
    );

    rv_pipe_follower u_pipe_follower (
        .clk     (clk),
        .rst     (rst),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .in_i    (dec_if.sink),
        .out_o   (wb_if.source)
    );

    // Output register ignores flush
    rv_wb_golden u_wb_golden (
        .clk            (clk),
        .rst            (rst),
        .stall_i        (stall_i),
        .in_i           (wb_if.sink),
        .rf_raddr1_o    (rf_raddr1_o),
        .rf_raddr2_o    (rf_raddr2_o),
        .rf_rdata1_i    (rf_rdata1_i),
        .rf_rdata2_i    (rf_rdata2_i),
        .wb_valid_o     (wb_valid_o),
        .illegal_o      (illegal_o),
        .gold_we_o      (gold_we_o),
        .wb_pc_o        (wb_pc_o),
        .gold_next_pc_o (gold_next_pc_o),
        .wb_inst_o      (wb_inst_o),
        .gold_rd_o      (gold_rd_o),
        .gold_data_o    (gold_data_o)
    );

endmodule

// File: verif/tb_rv_retire.sv
module tb_rv_retire;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int NUM_TESTS     = 6;
    localparam int STREAM_CYCLES = 60;
    localparam int DRAIN_LIMIT   = PIPE_STAGES + 8;
    localparam int WATCHDOG_NS   = NUM_TESTS * (STREAM_CYCLES + DRAIN_LIMIT + 4) * CLK_PERIOD + 200;

    logic     clk = 1'b0;
    logic     rst;
    logic     fetch_valid_i, stall_i, flush_i;
    inst_t    fetch_inst_i, wb_inst_o;
    addr_t    fetch_pc_i, wb_pc_o, gold_next_pc_o;
    word_t    rf_rdata1_i, rf_rdata2_i, gold_data_o;
    reg_idx_t rf_raddr1_o, rf_raddr2_o, gold_rd_o;
    logic     wb_valid_o, illegal_o, gold_we_o;

    word_t    rf_mem [32]; // Register file model, x0 entry is not zero
    inst_t    q_inst [$];  // Fetches still in flight
    addr_t    q_pc   [$];
    int       q_age  [$];  // Register stages passed so far
    addr_t    next_fetch_pc;
    int       err_count, pass_count, fail_count;

    // Expected contents of the output register
    logic     exp_valid, exp_illegal, exp_we, exp_writes;
    inst_t    exp_inst;
    addr_t    exp_pc, exp_next_pc;
    reg_idx_t exp_rd;
    word_t    exp_data;

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign rf_rdata1_i = rf_mem[rf_raddr1_o];
    assign rf_rdata2_i = rf_mem[rf_raddr2_o];

    rv_retire_model dut (.*);

    function automatic word_t read_reg(input reg_idx_t idx);
        return (idx == 5'd0) ? 32'd0 : rf_mem[idx];
    endfunction

    // RV32I legality as the ISA defines it
    function automatic logic rv32i_legal(input inst_t w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            OPC_LUI, OPC_AUIPC: return 1'b1;
            OPC_JAL:   return !w[21];                          // imm[1]
            OPC_JALR:  return f3 == 3'd0 && w[21:20] == 2'b00;
            OPC_B:     return f3 != 3'd2 && f3 != 3'd3 && !w[8];
            OPC_IL:    return f3 != 3'd3 && f3 < 3'd6;
            OPC_S:     return f3 < 3'd3;
            OPC_I: begin
                if (f3 == 3'd1) return f7 == 7'd0;            // SLLI
                if (f3 == 3'd5) return f7 == 7'd0 || f7 == 7'h20;
                return 1'b1;
            end
            OPC_R:     return f7 == 7'd0 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            OPC_FENCE: return f3 == 3'd0;
            OPC_E:     return w == 32'h0000_0073 || w == 32'h0010_0073;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic logic writes_rd_op(input inst_t w); // LUI, AUIPC or XORI
        return rv32i_legal(w) && (w[6:0] == OPC_LUI || w[6:0] == OPC_AUIPC ||
               (w[6:0] == OPC_I && w[14:12] == F3_XOR));
    endfunction

    function automatic word_t result_value(input inst_t w, input addr_t pc);
        word_t upper;
        upper = {w[31:12], 12'h000};
        if (w[6:0] == OPC_LUI) return upper;
        if (w[6:0] == OPC_AUIPC) return pc + upper;
        return read_reg(w[19:15]) ^ {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic addr_t next_pc_of(input inst_t w, input addr_t pc);
        word_t offset;
        offset = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        if (rv32i_legal(w) && w[6:0] == OPC_B && w[14:12] == F3_BLT &&
            $signed(read_reg(w[19:15])) < $signed(read_reg(w[24:20]))) return pc + offset;
        return pc + 32'd4;
    endfunction

    function automatic reg_idx_t pick_reg(); // x0 about a quarter of the time
        return ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
    endfunction

    function automatic inst_t make_inst(input int kind);
        logic [12:0] off;
        off = {11'($urandom), 2'b00};
        case (kind)
            0: return {20'($urandom), pick_reg(), OPC_LUI};
            1: return {20'($urandom), pick_reg(), OPC_AUIPC};
            2: return {12'($urandom), pick_reg(), F3_XOR, pick_reg(), OPC_I};
            3: return {off[12], off[10:5], pick_reg(), pick_reg(), F3_BLT, off[4:1], off[11], OPC_B};
            4: return $urandom;
            default: return make_inst($urandom_range(0, 3)) ^ (32'h1 << $urandom_range(0, 31));
        endcase
    endfunction

    task automatic report_err(input string msg);
        err_count++;
        $display("ERR %0t ns: %s", $time, msg);
    endtask

    // Front entry moves into the output register once it sits in the last buffer stage
    task automatic load_output();
        inst_t w;
        addr_t pc;
        if (q_age.size() == 0 || q_age[0] != PIPE_STAGES + 1) begin
            exp_valid <= 1'b0;
        end else begin
            w  = q_inst.pop_front();
            pc = q_pc.pop_front();
            void'(q_age.pop_front());
            exp_valid   <= 1'b1;
            exp_inst    <= w;
            exp_pc      <= pc;
            exp_illegal <= !rv32i_legal(w);
            exp_writes  <= writes_rd_op(w);
            exp_we      <= writes_rd_op(w) && w[11:7] != 5'd0;
            exp_rd      <= w[11:7];
            exp_data    <= result_value(w, pc);
            exp_next_pc <= next_pc_of(w, pc);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            q_inst.delete();
            q_pc.delete();
            q_age.delete();
            exp_valid <= 1'b0;
        end else if (flush_i) begin
            if (!stall_i) load_output();
            q_inst.delete(); // Nothing younger survives
            q_pc.delete();
            q_age.delete();
        end else if (!stall_i) begin
            load_output();
            foreach (q_age[i]) q_age[i] = q_age[i] + 1;
            if (fetch_valid_i) begin
                q_inst.push_back(fetch_inst_i);
                q_pc.push_back(fetch_pc_i);
                q_age.push_back(1);
            end
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (rst) wb_valid_o == exp_valid)
        else report_err($sformatf("wb_valid_o is %b, expected %b",
                                  $sampled(wb_valid_o), $sampled(exp_valid)));
    a_order: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> wb_pc_o == exp_pc && wb_inst_o == exp_inst)
        else report_err($sformatf("retired pc %h, expected %h",
                                  $sampled(wb_pc_o), $sampled(exp_pc)));
    a_illegal: assert property (@(posedge clk) disable iff (rst)
        illegal_o == (exp_valid && exp_illegal))
        else report_err($sformatf("illegal_o wrong for %h", $sampled(exp_inst)));
    a_we: assert property (@(posedge clk) disable iff (rst) gold_we_o == (exp_valid && exp_we))
        else report_err($sformatf("gold_we_o wrong for %h", $sampled(exp_inst)));
    a_data: assert property (@(posedge clk) disable iff (rst)
        exp_valid && exp_writes |-> gold_rd_o == exp_rd && gold_data_o == exp_data)
        else report_err($sformatf("gold_data_o %h, expected %h",
                                  $sampled(gold_data_o), $sampled(exp_data)));
    a_next_pc: assert property (@(posedge clk) disable iff (rst)
        exp_valid && !exp_illegal |-> gold_next_pc_o == exp_next_pc)
        else report_err($sformatf("next pc %h, expected %h",
                                  $sampled(gold_next_pc_o), $sampled(exp_next_pc)));
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall_i |=> $stable({wb_valid_o, wb_pc_o, wb_inst_o, illegal_o, gold_we_o,
                             gold_rd_o, gold_data_o, gold_next_pc_o}))
        else report_err("outputs changed during a stall");

    task automatic run_stream(input int lo, input int hi, input int stall_pct, input int flush_pct);
        int stall_left;
        stall_left = 0;
        repeat (STREAM_CYCLES) begin
            @(posedge clk);
            #1;
            fetch_valid_i = ($urandom_range(0, 3) != 0);
            fetch_inst_i  = make_inst($urandom_range(lo, hi));
            fetch_pc_i    = next_fetch_pc;
            next_fetch_pc = next_fetch_pc + 32'd4; // Unique PCs expose reordering
            if (stall_left > 0) begin
                stall_left--;
                stall_i = 1'b1;
            end else if ($urandom_range(0, 99) < stall_pct) begin
                stall_left = $urandom_range(0, 6);
                stall_i    = 1'b1;
            end else begin
                stall_i = 1'b0;
            end
            flush_i = ($urandom_range(0, 99) < flush_pct);
        end
    endtask

    task automatic run_test(input string name, input int lo, input int hi,
                            input int stall_pct, input int flush_pct);
        int errs_before;
        errs_before = err_count;
        foreach (rf_mem[i]) rf_mem[i] = $urandom;
        run_stream(lo, hi, stall_pct, flush_pct);
        @(posedge clk);
        #1;
        fetch_valid_i = 1'b0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        for (int i = 0; i < DRAIN_LIMIT && q_inst.size() != 0; i++) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
        if (err_count == errs_before) begin
            pass_count++;
            $display("Test %s done, no errors", name);
        end else begin
            fail_count++;
            $display("Test %s done, %0d errors", name, err_count - errs_before);
        end
    endtask

    initial begin
        void'($urandom(32'h914e));
        rst           = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_inst_i  = NOP_INST;
        fetch_pc_i    = PC_INIT;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        next_fetch_pc = 32'h0000_1000;
        foreach (rf_mem[i]) rf_mem[i] = $urandom;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        run_test("order_latency", 0, 3, 0, 0);
        run_test("alu_golden", 0, 2, 0, 0);
        run_test("blt_next_pc", 3, 3, 0, 0);
        run_test("legality", 4, 5, 0, 0);
        run_test("stall_hold", 0, 5, 20, 0);
        run_test("flush_drop", 0, 5, 15, 8);
        $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns before all tests finished", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule

// File: flist.f
design/rv_pkg.sv
design/stage_if.sv
design/rv_fetch_decode.sv
design/rv_pipe_follower.sv
design/rv_wb_golden.sv
design/rv_retire_model.sv
verif/tb_rv_retire.sv
